// File: clkgen_top.f
common/clk_cfg_pkg.sv
common/clk_bus_pkg.sv
src/clock_divider.sv
cfg/cfg_regs.sv
cfg/cfg_arbiter.sv
cfg/freq_stepper.sv
src/clkgen_top.sv
sim/clkgen_assert.sv
sim/clkgen_tb.sv

// File: Makefile
# Verilator build and run for the clock generator testbench

TOP = clkgen_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f clkgen_top.f --top-module $(TOP) -o V$(TOP)

run: build
	./obj_dir/V$(TOP)

lint:
	verilator --lint-only --timing --assert -f clkgen_top.f --top-module $(TOP)

clean:
	rm -rf obj_dir

// File: sim/clkgen_tb.sv
/*
 * clock generator testbench
 * host writes, cycle-exact reference model, stepper walk checks
 */

`timescale 1ns/1ns

module clkgen_tb;

   logic                                           clk;
   logic                                           nreset;
   clk_bus_pkg::bus_req_t                          host_req;
   clk_cfg_pkg::ch_out_t [clk_cfg_pkg::NUM_CH-1:0] ch_out;
   logic                                           busy;

   clk_cfg_pkg::ch_cfg_t model_cfg [clk_cfg_pkg::NUM_CH];  // expected settings
   int                   start_cyc [clk_cfg_pkg::NUM_CH];  // first cycle after chg
   bit                   tracking  [clk_cfg_pkg::NUM_CH];
   int                   cyc;                              // negedges seen
   integer               seed;

   clkgen_top #(.COUNT_W(8)) clkgen_top_i (
      .clk,
      .nreset,
      .host_req,
      .ch_out,
      .busy
   );

   always #20 clk = ~clk;  // 40 ns period

   // ########################################
   // reference model and checks
   // ########################################

   function automatic clk_cfg_pkg::ch_out_t predict_out(input clk_cfg_pkg::ch_cfg_t c,
                                                        input int k);
      clk_cfg_pkg::ch_out_t o;
      int per;
      int cnt;
      o = '0;
      if (!c.en)
         return o;  // counter parked at 0 with no pulses
      per = int'(c.div) + 1;
      for (int j = 0; j < k; j++) begin
         cnt = j % per;
         if (cnt == int'(c.rise0)) o.clkout0 = 1'b1;
         else if (cnt == int'(c.fall0)) o.clkout0 = 1'b0;
         if (cnt == int'(c.rise1)) o.clkout1 = 1'b1;
         else if (cnt == int'(c.fall1)) o.clkout1 = 1'b0;
      end
      cnt      = k % per;
      o.rise0  = (cnt == int'(c.rise0));
      o.fall0  = (cnt == int'(c.fall0));
      o.rise1  = (cnt == int'(c.rise1));
      o.fall1  = (cnt == int'(c.fall1));
      o.stable = (k / per) >= 7;  // seven wraps completed
      return o;
   endfunction

   task automatic fail_now(input string msg);
      $display("%s", msg);
      $display("Regression failed");
      $fatal(1);
   endtask

   task automatic check_out(input clk_cfg_pkg::ch_out_t got, input clk_cfg_pkg::ch_out_t exp,
                            input int ch);
      if (got !== exp)
         fail_now($sformatf("CHECK FAILED at %0t: ch%0d outputs %b, expected %b",
                            $time, ch, got, exp));
   endtask

   task automatic check_busy(input logic got, input logic exp);
      if (got !== exp)
         fail_now($sformatf("CHECK FAILED at %0t: busy %b, expected %b", $time, got, exp));
   endtask

   task automatic check_div(input logic [7:0] got, input logic [7:0] exp);
      if (got !== exp)
         fail_now($sformatf("CHECK FAILED at %0t: div %0d, expected %0d", $time, got, exp));
   endtask

   // compare at the falling edge where outputs have settled
   always @(negedge clk) begin
      for (int i = 0; i < clk_cfg_pkg::NUM_CH; i++)
         if (nreset && tracking[i] && cyc >= start_cyc[i])
            check_out(ch_out[i], predict_out(model_cfg[i], cyc - start_cyc[i]), i);
      cyc = cyc + 1;
   end

   // ########################################
   // stimulus
   // ########################################

   task automatic host_write(input logic ch, input clk_cfg_pkg::reg_addr_e addr,
                             input logic [15:0] data);
      clk_bus_pkg::bus_req_t req;
      logic [7:0]            per;
      req.valid = 1'b1;
      req.ch    = ch;
      req.addr  = addr;
      req.data  = data;
      per       = (data[7:0] == 8'd0) ? 8'd1 : data[7:0];  // 0 runs as 1
      @(posedge clk);
      host_req <= req;
      @(posedge clk);
      host_req.valid <= 1'b0;  // DUT takes the write at this edge
      case (addr)
         clk_cfg_pkg::REG_DIV:    model_cfg[ch].div = per;
         clk_cfg_pkg::REG_PHASE0: {model_cfg[ch].fall0, model_cfg[ch].rise0} = data;
         clk_cfg_pkg::REG_PHASE1: {model_cfg[ch].fall1, model_cfg[ch].rise1} = data;
         clk_cfg_pkg::REG_CTRL:   model_cfg[ch].en = data[0];
         default: ;
      endcase
      if (addr != clk_cfg_pkg::REG_TARGET)
         start_cyc[ch] = cyc + 1;  // skip the chg cycle
   endtask

   // follow the stepper one count per settled interval until on target
   task automatic watch_steps(input int ch, input logic [7:0] tgt);
      logic [7:0] prev;
      logic [7:0] d;
      bit         done;
      prev = model_cfg[ch].div;  // last host setting
      done = 0;
      for (int t = 0; t < 8000 && !done; t++) begin
         @(negedge clk);
         d = clkgen_top_i.cfg[ch].div;
         if (d != prev) begin
            check_div(d, (prev < tgt) ? prev + 8'd1 : prev - 8'd1);
            if (!ch_out[ch].stable)
               fail_now("period stepped before the channel had settled");
            prev = d;
         end
         if (prev == tgt)
            done = 1;
         else
            check_busy(busy, 1'b1);  // still off target
      end
      if (!done)
         fail_now("timed out waiting for the stepper to reach its target");
      check_busy(busy, 1'b0);  // drops in the cycle the target is reached
   endtask

   task automatic setup_ch(input logic ch, input logic [7:0] div, input logic [15:0] ph0,
                           input logic [15:0] ph1);
      host_write(ch, clk_cfg_pkg::REG_DIV, {8'h00, div});
      host_write(ch, clk_cfg_pkg::REG_PHASE0, ph0);
      host_write(ch, clk_cfg_pkg::REG_PHASE1, ph1);
      host_write(ch, clk_cfg_pkg::REG_CTRL, 16'h0001);
   endtask

   initial begin
      logic [31:0] r;
      seed       = 32'hb25;
      clk        = 1'b0;
      nreset     = 1'b0;
      host_req   <= '0;
      cyc        = 0;
      for (int i = 0; i < clk_cfg_pkg::NUM_CH; i++) begin
         model_cfg[i] = clk_cfg_pkg::CFG_RST;
         start_cyc[i] = 0;
         tracking[i]  = 1;
      end
      repeat (8) @(posedge clk);
      nreset <= 1'b1;
      repeat (20) @(negedge clk);
      check_busy(busy, 1'b0);

      // phases programmed with en still clear stay quiet
      host_write(1'b0, clk_cfg_pkg::REG_PHASE0, 16'h0200);
      repeat (10) @(negedge clk);
      setup_ch(1'b0, 8'd3, 16'h0200, 16'h0301);
      repeat (60) @(negedge clk);
      host_write(1'b0, clk_cfg_pkg::REG_PHASE1, 16'h0103);  // drops stable
      repeat (50) @(negedge clk);
      setup_ch(1'b1, 8'd0, 16'h0100, 16'h0001);  // clamped to period 2
      repeat (30) @(negedge clk);
      setup_ch(1'b1, 8'd8, 16'h0400, 16'h0806);
      repeat (90) @(negedge clk);

      // ch0 up with host writes to ch1 landing during the walk
      tracking[0] = 0;
      host_write(1'b0, clk_cfg_pkg::REG_TARGET, 16'h0006);
      fork
         watch_steps(0, 8'd6);
         begin
            repeat (15) @(negedge clk);
            host_write(1'b1, clk_cfg_pkg::REG_PHASE0, 16'h0502);
            repeat (37) @(negedge clk);
            host_write(1'b1, clk_cfg_pkg::REG_PHASE1, 16'h0003);
         end
      join
      host_write(1'b0, clk_cfg_pkg::REG_DIV, 16'h0006);
      tracking[0] = 1;
      repeat (90) @(negedge clk);

      // ch1 down
      tracking[1] = 0;
      host_write(1'b1, clk_cfg_pkg::REG_TARGET, 16'h0005);
      watch_steps(1, 8'd5);
      host_write(1'b1, clk_cfg_pkg::REG_DIV, 16'h0005);
      tracking[1] = 1;
      repeat (60) @(negedge clk);

      // random rounds
      for (int n = 0; n < 6; n++) begin
         r = $random(seed);
         setup_ch(r[8], {4'h0, r[3:0]}, {4'h0, r[19:16], 4'h0, r[23:20]},
                  {4'h0, r[27:24], 4'h0, r[31:28]});
         repeat (8 * (int'(r[3:0]) + 2) + 10) @(negedge clk);
      end

      repeat (5) @(negedge clk);
      $display("Regression passed");
      $finish;
   end

endmodule

// File: sim/clkgen_assert.sv
/*
 * bound assertions for the clock generator
 * stepper request hold, stable flag and match pulse sanity
 */

`timescale 1ns/1ns

module clkgen_assert (
   input logic                                          clk,
   input logic                                          nreset,
   input clk_bus_pkg::bus_req_t                         step_req,
   input logic                                          step_gnt,
   input logic [clk_cfg_pkg::NUM_CH-1:0]                chg,
   input clk_cfg_pkg::ch_out_t [clk_cfg_pkg::NUM_CH-1:0] ch_out
);

   // stepper request lost to the host stays up for the retry
   a_req_held: assert property (@(posedge clk) disable iff (!nreset)
      step_req.valid && !step_gnt |=> step_req.valid)
      else $error("stepper request dropped before its grant");

   // ########################################
   // per channel divider checks
   // ########################################
   for (genvar i = 0; i < clk_cfg_pkg::NUM_CH; i++) begin : g_chk
      a_stable_hold: assert property (@(posedge clk) disable iff (!nreset)
         ch_out[i].stable && !chg[i] |=> ch_out[i].stable)
         else $error("stable fell without a settings change");

      // rise pulse lasts a single cycle of each period
      a_rise_once: assert property (@(posedge clk) disable iff (!nreset)
         $past(ch_out[i].rise0 && !chg[i]) && !chg[i] |-> !ch_out[i].rise0)
         else $error("rise pulse longer than one cycle");
   end

endmodule

bind clkgen_top clkgen_assert clkgen_assert_i (
   .clk,
   .nreset,
   .step_req,
   .step_gnt,
   .chg,
   .ch_out
);

// File: src/clkgen_top.sv
/*
 * two-channel programmable clock generator
 * host and stepper share the register bus, registers feed two dividers
 */

`timescale 1ns/1ns

module clkgen_top #(
   parameter int COUNT_W = 8
) (
   input  logic                                          clk,
   input  logic                                          nreset,
   input  clk_bus_pkg::bus_req_t                         host_req,
   output clk_cfg_pkg::ch_out_t [clk_cfg_pkg::NUM_CH-1:0] ch_out,
   output logic                                          busy      // stepping in progress
);

   clk_bus_pkg::bus_req_t                             step_req;
   clk_bus_pkg::bus_req_t                             bus;
   logic                                              bus_step;
   logic                                              step_gnt;
   clk_cfg_pkg::ch_cfg_t [clk_cfg_pkg::NUM_CH-1:0]    cfg;
   logic [clk_cfg_pkg::NUM_CH-1:0]                    chg;
   logic [clk_cfg_pkg::NUM_CH-1:0][COUNT_W-1:0]       target;
   logic [clk_cfg_pkg::NUM_CH-1:0][7:0]               cur_div;
   logic [clk_cfg_pkg::NUM_CH-1:0]                    stable;

   cfg_arbiter cfg_arbiter_i (
      .host_req,
      .step_req,
      .bus,
      .bus_step,
      .step_gnt
   );

   cfg_regs #(.COUNT_W(COUNT_W)) cfg_regs_i (
      .clk,
      .nreset,
      .bus,
      .bus_step,
      .cfg,
      .chg,
      .target
   );

   freq_stepper freq_stepper_i (
      .clk,
      .nreset,
      .cur_div,
      .target,
      .stable,
      .step_gnt,
      .step_req,
      .busy
   );

   // one divider per channel
   for (genvar i = 0; i < clk_cfg_pkg::NUM_CH; i++) begin : g_ch
      assign cur_div[i] = cfg[i].div;
      assign stable[i]  = ch_out[i].stable;  // back to stepper

      clock_divider #(.COUNT_W(COUNT_W)) clock_divider_i (
         .clk,
         .nreset,
         .cfg (cfg[i]),
         .chg (chg[i]),
         .out (ch_out[i])
      );
   end

endmodule

// File: cfg/freq_stepper.sv
/*
 * frequency stepper
 * walks each channel's period one count at a time toward its
 * target, waiting for the divider to settle between steps
 */

`timescale 1ns/1ns

module freq_stepper (
   input  logic                                      clk,
   input  logic                                      nreset,
   input  logic [clk_cfg_pkg::NUM_CH-1:0][7:0]       cur_div,
   input  logic [clk_cfg_pkg::NUM_CH-1:0][7:0]       target,
   input  logic [clk_cfg_pkg::NUM_CH-1:0]            stable,
   input  logic                                      step_gnt,
   output clk_bus_pkg::bus_req_t                     step_req,
   output logic                                      busy
);

   clk_bus_pkg::step_state_e          state;
   clk_bus_pkg::step_dir_e            dir;
   logic                              ptr;        // channel being stepped
   logic                              seen_low;   // stable dropped after our write
   logic [clk_cfg_pkg::NUM_CH-1:0]    off_target;
   logic [clk_cfg_pkg::NUM_CH-1:0]    ready;      // off target and settled
   logic                              pick;
   logic [7:0]                        next_div;

   always_comb begin
      for (int i = 0; i < clk_cfg_pkg::NUM_CH; i++) begin
         off_target[i] = (cur_div[i] != target[i]);
         ready[i]      = off_target[i] & stable[i];
      end
   end

   // lowest ready channel first
   always_comb begin
      pick = 1'b0;
      for (int i = clk_cfg_pkg::NUM_CH - 1; i >= 0; i--)
         if (ready[i])
            pick = 1'(i);
   end

   assign busy = |off_target;

   // ######################################
   // step FSM
   // ######################################

   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         state    <= clk_bus_pkg::STEP_IDLE;
         dir      <= clk_bus_pkg::DIR_UP;
         ptr      <= 1'b0;
         seen_low <= 1'b0;
      end else begin
         case (state)
            clk_bus_pkg::STEP_IDLE: begin
               if (|ready) begin
                  ptr   <= pick;
                  dir   <= (target[pick] > cur_div[pick]) ? clk_bus_pkg::DIR_UP
                                                          : clk_bus_pkg::DIR_DOWN;
                  state <= clk_bus_pkg::STEP_REQ;
               end
            end
            clk_bus_pkg::STEP_REQ: begin
               if (step_gnt) begin
                  seen_low <= 1'b0;
                  state    <= clk_bus_pkg::STEP_SETTLE;
               end
            end
            clk_bus_pkg::STEP_SETTLE: begin
               if (!stable[ptr])
                  seen_low <= 1'b1;  // divider restarted
               else if (seen_low)
                  state <= clk_bus_pkg::STEP_IDLE;  // settled again
            end
            default: state <= clk_bus_pkg::STEP_IDLE;
         endcase
      end
   end

   // ######################################
   // bus request
   // ######################################

   // from live div, so a host write just before the grant is honored
   assign next_div = (dir == clk_bus_pkg::DIR_UP) ? cur_div[ptr] + 8'd1
                                                  : cur_div[ptr] - 8'd1;

   always_comb begin
      step_req.valid = (state == clk_bus_pkg::STEP_REQ);
      step_req.ch    = ptr;
      step_req.addr  = clk_cfg_pkg::REG_DIV;
      step_req.data  = {8'h00, next_div};
   end

endmodule

// File: cfg/cfg_arbiter.sv
/*
 * register bus arbiter
 * fixed priority, host over stepper, host never stalled
 */

`timescale 1ns/1ns

module cfg_arbiter (
   input  clk_bus_pkg::bus_req_t host_req,  // one-cycle strobes
   input  clk_bus_pkg::bus_req_t step_req,  // level until granted
   output clk_bus_pkg::bus_req_t bus,
   output logic                  bus_step,  // stepper owns this cycle
   output logic                  step_gnt
);

   // ######################################
   // priority mux
   // ######################################

   always_comb begin
      if (host_req.valid) begin
         bus      = host_req;  // host always wins
         bus_step = 1'b0;
      end else begin
         bus      = step_req;  // idle bus carries stepper, valid may be low
         bus_step = 1'b1;
      end
   end

   // stepper keeps its request up, so a lost cycle is retried
   assign step_gnt = step_req.valid & ~host_req.valid;

endmodule

// File: cfg/cfg_regs.sv
/*
 * configuration register block
 * decodes bus writes per channel, clamps periods, holds stepper
 * targets and pulses chg on every settings update
 */

`timescale 1ns/1ns

module cfg_regs #(
   parameter int COUNT_W = 8
) (
   input  logic                                             clk,
   input  logic                                             nreset,
   input  clk_bus_pkg::bus_req_t                            bus,
   input  logic                                             bus_step,  // stepper owns bus
   output clk_cfg_pkg::ch_cfg_t [clk_cfg_pkg::NUM_CH-1:0]   cfg,
   output logic [clk_cfg_pkg::NUM_CH-1:0]                   chg,
   output logic [clk_cfg_pkg::NUM_CH-1:0][COUNT_W-1:0]      target
);

   logic [COUNT_W-1:0] wr_period;  // clamped period from write data

   // period 0 would be a bypass, run it as divide by 2 instead
   assign wr_period = (bus.data[COUNT_W-1:0] == '0) ? COUNT_W'(1) : bus.data[COUNT_W-1:0];

   // ######################################
   // register write decode
   // ######################################

   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         for (int i = 0; i < clk_cfg_pkg::NUM_CH; i++) begin
            cfg[i]    <= clk_cfg_pkg::CFG_RST;
            target[i] <= COUNT_W'(1);  // equals div, so stepper idle
         end
         chg <= '0;
      end else begin
         chg <= '0;  // single-cycle pulse
         if (bus.valid) begin
            case (bus.addr)
               clk_cfg_pkg::REG_DIV: begin
                  cfg[bus.ch].div <= wr_period;
                  if (!bus_step)
                     target[bus.ch] <= wr_period;  // host write sets new goal
                  chg[bus.ch] <= 1'b1;
               end
               clk_cfg_pkg::REG_PHASE0: begin
                  cfg[bus.ch].rise0 <= bus.data[7:0];
                  cfg[bus.ch].fall0 <= bus.data[15:8];
                  chg[bus.ch]       <= 1'b1;
               end
               clk_cfg_pkg::REG_PHASE1: begin
                  cfg[bus.ch].rise1 <= bus.data[7:0];
                  cfg[bus.ch].fall1 <= bus.data[15:8];
                  chg[bus.ch]       <= 1'b1;
               end
               clk_cfg_pkg::REG_CTRL: begin
                  cfg[bus.ch].en <= bus.data[0];
                  chg[bus.ch]    <= 1'b1;
               end
               clk_cfg_pkg::REG_TARGET: begin
                  target[bus.ch] <= wr_period;  // no chg, divider untouched
               end
               default: begin
                  // unmapped address, write ignored
               end
            endcase
         end
      end
   end

endmodule

// File: src/clock_divider.sv
/*
 * clock divider channel
 * programmable period counter, two registered output clocks with
 * rise/fall match pulses, stable flag after seven settled periods
 */

`timescale 1ns/1ns

module clock_divider #(
   parameter int COUNT_W = 8
) (
   input  logic                 clk,
   input  logic                 nreset,
   input  clk_cfg_pkg::ch_cfg_t cfg,
   input  logic                 chg,     // settings changed, restart
   output clk_cfg_pkg::ch_out_t out
);

   logic [COUNT_W-1:0] counter;       // cycle counter, 0..div
   logic [2:0]         periods;       // settled periods since chg
   logic               stable;
   logic               period_match;
   logic               rise0;
   logic               fall0;
   logic               rise1;
   logic               fall1;
   logic               clkout0;
   logic               clkout1;

   // ######################################
   // cycle counter
   // ######################################

   assign period_match = cfg.en & (counter == COUNT_W'(cfg.div));  // wrap point

   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         counter <= '0;
      end else if (chg) begin
         counter <= '0;  // restart so a shorter period can't be overrun
      end else if (cfg.en) begin
         if (period_match)
            counter <= '0;
         else
            counter <= counter + 1'b1;
      end
   end

   // ######################################
   // stable detect
   // ######################################

   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         periods <= '0;
      end else if (chg) begin
         periods <= '0;
      end else if (period_match && !stable) begin
         periods <= periods + 3'd1;  // saturates via stable
      end
   end

   assign stable = (periods == 3'd7);  // seven wraps seen, then hold

   // ######################################
   // edge selectors
   // ######################################

   // match pulses only while counting, so idle channel stays quiet
   assign rise0 = cfg.en & (counter == COUNT_W'(cfg.rise0));
   assign fall0 = cfg.en & (counter == COUNT_W'(cfg.fall0));
   assign rise1 = cfg.en & (counter == COUNT_W'(cfg.rise1));
   assign fall1 = cfg.en & (counter == COUNT_W'(cfg.fall1));

   // ######################################
   // output clocks
   // ######################################

   // registered on rising edge only, no bypass path
   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         clkout0 <= 1'b0;
         clkout1 <= 1'b0;
      end else if (chg) begin
         clkout0 <= 1'b0;  // restart from low phase
         clkout1 <= 1'b0;
      end else begin
         if (rise0)
            clkout0 <= 1'b1;  // rise wins if both match
         else if (fall0)
            clkout0 <= 1'b0;
         if (rise1)
            clkout1 <= 1'b1;
         else if (fall1)
            clkout1 <= 1'b0;
      end
   end

   always_comb begin
      out.clkout0 = clkout0;
      out.clkout1 = clkout1;
      out.rise0   = rise0;
      out.fall0   = fall0;
      out.rise1   = rise1;
      out.fall1   = fall1;
      out.stable  = stable;
   end

endmodule

// File: common/clk_bus_pkg.sv
/*
 * configuration write bus types
 * bus request shared by host and stepper, stepper FSM encodings
 */

package clk_bus_pkg;

   // one write on the shared bus
   typedef struct packed {
      logic                  valid;  // write strobe
      logic                  ch;     // channel select
      clk_cfg_pkg::reg_addr_e addr;
      logic [15:0]           data;
   } bus_req_t;

   // frequency stepper FSM
   typedef enum logic [1:0] {
      STEP_IDLE   = 2'd0,  // looking for an off-target channel
      STEP_REQ    = 2'd1,  // request held until granted
      STEP_SETTLE = 2'd2   // waiting for stable to drop and return
   } step_state_e;

   typedef enum logic {
      DIR_UP   = 1'b0,  // period grows, frequency drops
      DIR_DOWN = 1'b1
   } step_dir_e;

endpackage

// File: common/clk_cfg_pkg.sv
/*
 * clock generator configuration types
 * per-channel divider settings, divider output bundle, register map
 */

package clk_cfg_pkg;

   localparam int NUM_CH = 2;  // divider channels

   // ######################################
   // channel settings
   // ######################################
   typedef struct packed {
      logic [7:0] div;    // period minus one, never 0
      logic [7:0] rise0;  // clkout0 rising match
      logic [7:0] fall0;  // clkout0 falling match
      logic [7:0] rise1;  // clkout1 rising match
      logic [7:0] fall1;  // clkout1 falling match
      logic       en;     // counter enable
   } ch_cfg_t;

   // settings after reset: divide by 2, everything else off
   localparam ch_cfg_t CFG_RST = '{div: 8'd1, default: '0};

   // divider outputs of one channel
   typedef struct packed {
      logic clkout0;
      logic clkout1;
      logic rise0;   // match pulses
      logic fall0;
      logic rise1;
      logic fall1;
      logic stable;  // settled after last change
   } ch_out_t;

   // register map, one set per channel
   typedef enum logic [2:0] {
      REG_DIV    = 3'd0,  // [7:0] period, also sets target
      REG_PHASE0 = 3'd1,  // [7:0] rise, [15:8] fall
      REG_PHASE1 = 3'd2,
      REG_CTRL   = 3'd3,  // [0] en
      REG_TARGET = 3'd4   // [7:0] target period for stepper
   } reg_addr_e;

endpackage
